// File: logic/chkpt_pkg.sv
`default_nettype none

package chkpt_pkg;

	// Ring and checkpoint sizes.
	localparam int GROUP_COUNT = 8;
	localparam int CHKPT_COUNT = 8;

	localparam int GRP_W = $clog2(GROUP_COUNT);
	localparam int CNDX_W = $clog2(CHKPT_COUNT);

	// One extra bit so that ages compare correctly across a ring wrap.
	localparam int SEQ_W = GRP_W + 1;

	typedef logic [GRP_W-1:0] grp_ndx_t;
	typedef logic [CNDX_W-1:0] checkpt_ndx_t;
	typedef logic [SEQ_W-1:0] seq_t;

	// States of the checkpoint manager.
	typedef enum logic [2:0] {
		idle,
		alloc1,
		alloc2,
		set,
		backout
	} chkpt_state_t;

endpackage

`default_nettype wire

// File: logic/group_table.sv
`timescale 1ns/1ps
`default_nettype none

module group_table (
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input logic disp_has_branch,
	output logic disp_ready,
	input logic commit_valid,
	output logic commit_ready,
	input logic setcp,
	input chkpt_pkg::grp_ndx_t setcp_grp,
	input chkpt_pkg::checkpt_ndx_t cndx,
	input logic bko_busy,
	input logic squash,
	input chkpt_pkg::grp_ndx_t miss_grp,
	output logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_valid,
	output logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_branch,
	output logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_cndxv,
	output logic [chkpt_pkg::GROUP_COUNT*chkpt_pkg::CNDX_W-1:0] hdr_cndx,
	output logic [chkpt_pkg::GROUP_COUNT*chkpt_pkg::SEQ_W-1:0] hdr_sn,
	output chkpt_pkg::grp_ndx_t head,
	output chkpt_pkg::grp_ndx_t tail
);
	import chkpt_pkg::*;

	logic [GROUP_COUNT-1:0] valid;
	logic [GROUP_COUNT-1:0] branch;
	logic [GROUP_COUNT-1:0] cndxv;
	logic [GROUP_COUNT-1:0] younger;
	checkpt_ndx_t grp_cndx [GROUP_COUNT];
	seq_t grp_sn [GROUP_COUNT];
	seq_t next_sn;
	seq_t miss_sn;
	logic disp_fire;
	logic commit_fire;

	// Only one group may wait for its checkpoint, so dispatch stops while one does.
	assign disp_ready = !(|(valid & ~cndxv)) && !bko_busy && !squash && !valid[tail];
	assign commit_ready = valid[head] && cndxv[head] && !bko_busy && !squash;

	assign disp_fire = disp_valid && disp_ready;
	assign commit_fire = commit_valid && commit_ready;

	assign miss_sn = grp_sn[miss_grp];

	// A slot is younger than the miss group when its age difference is positive.
	always_comb begin
		seq_t age;
		for (int i = 0; i < GROUP_COUNT; i++) begin
			age = grp_sn[i] - miss_sn;
			younger[i] = (age != '0) && !age[SEQ_W-1];
		end
	end

	assign hdr_valid = valid;
	assign hdr_branch = branch;
	assign hdr_cndxv = cndxv;

	always_comb begin
		for (int i = 0; i < GROUP_COUNT; i++) begin
			hdr_cndx[i*CNDX_W +: CNDX_W] = grp_cndx[i];
			hdr_sn[i*SEQ_W +: SEQ_W] = grp_sn[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
			cndxv <= '0;
			head <= '0;
			tail <= '0;
			next_sn <= '0;
		end else begin
			if (disp_fire) begin
				valid[tail] <= 1'b1;
				cndxv[tail] <= 1'b0;
				tail <= tail + 1'b1;
				next_sn <= next_sn + 1'b1;
			end
			if (setcp)
				cndxv[setcp_grp] <= 1'b1;
			if (commit_fire) begin
				valid[head] <= 1'b0;
				head <= head + 1'b1;
			end
			if (squash) begin
				valid <= valid & ~younger;
				tail <= miss_grp + 1'b1;
				next_sn <= miss_sn + 1'b1;
			end
		end
	end

	// The current index is stored at dispatch as a provisional value.
	always_ff @(posedge clk) begin
		if (disp_fire) begin
			branch[tail] <= disp_has_branch;
			grp_cndx[tail] <= cndx;
			grp_sn[tail] <= next_sn;
		end
		if (setcp)
			grp_cndx[setcp_grp] <= cndx;
	end

endmodule

`default_nettype wire

// File: logic/chkpt_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module chkpt_allocator (
	input logic clk,
	input logic rst,
	input logic alloc_req,
	input logic cmt_free,
	input chkpt_pkg::checkpt_ndx_t cmt_chkpt,
	input logic bko_free,
	input chkpt_pkg::checkpt_ndx_t bko_chkpt,
	output chkpt_pkg::checkpt_ndx_t avail,
	output logic stall
);
	import chkpt_pkg::*;

	// One bit per checkpoint, set while the checkpoint is free.
	logic [CHKPT_COUNT-1:0] free_map;

	// Offer the lowest free checkpoint.
	always_comb begin
		avail = '0;
		for (int i = CHKPT_COUNT - 1; i >= 0; i--) begin
			if (free_map[i])
				avail = checkpt_ndx_t'(i);
		end
	end

	assign stall = ~|free_map;

	// Checkpoint 0 is the current index out of reset, so it starts in use.
	always_ff @(posedge clk) begin
		if (rst) begin
			free_map <= {{(CHKPT_COUNT - 1){1'b1}}, 1'b0};
		end else begin
			if (alloc_req)
				free_map[avail] <= 1'b0;
			if (cmt_free)
				free_map[cmt_chkpt] <= 1'b1;
			if (bko_free)
				free_map[bko_chkpt] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/chkpt_freer.sv
`timescale 1ns/1ps
`default_nettype none

module chkpt_freer (
	input logic clk,
	input logic rst,
	input logic commit_fire,
	input chkpt_pkg::grp_ndx_t head,
	input logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_valid,
	input logic [chkpt_pkg::GROUP_COUNT*chkpt_pkg::CNDX_W-1:0] hdr_cndx,
	input chkpt_pkg::checkpt_ndx_t cndx,
	output logic cmt_free,
	output chkpt_pkg::checkpt_ndx_t cmt_chkpt,
	output chkpt_pkg::grp_ndx_t freecp_grp
);
	import chkpt_pkg::*;

	grp_ndx_t next_grp;
	checkpt_ndx_t head_cndx;
	checkpt_ndx_t next_cndx;
	logic differs;

	assign next_grp = head + 1'b1;
	assign head_cndx = hdr_cndx[head*CNDX_W +: CNDX_W];

	// Valid groups are contiguous from the head, so a valid next slot is the successor.
	// With no successor the current index is the only other user.
	assign next_cndx = hdr_valid[next_grp] ? hdr_cndx[next_grp*CNDX_W +: CNDX_W] : cndx;
	assign differs = head_cndx != next_cndx;

	always_ff @(posedge clk) begin
		if (rst)
			cmt_free <= 1'b0;
		else
			cmt_free <= commit_fire && differs;
	end

	always_ff @(posedge clk) begin
		if (commit_fire) begin
			cmt_chkpt <= head_cndx;
			freecp_grp <= head;
		end
	end

endmodule

`default_nettype wire

// File: logic/chkpt_manager.sv
`timescale 1ns/1ps
`default_nettype none

module chkpt_manager (
	input logic clk,
	input logic rst,
	input logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_valid,
	input logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_branch,
	input logic [chkpt_pkg::GROUP_COUNT-1:0] hdr_cndxv,
	input logic [chkpt_pkg::GROUP_COUNT*chkpt_pkg::CNDX_W-1:0] hdr_cndx,
	input logic [chkpt_pkg::GROUP_COUNT*chkpt_pkg::SEQ_W-1:0] hdr_sn,
	input chkpt_pkg::grp_ndx_t tail,
	input logic restore,
	input chkpt_pkg::grp_ndx_t miss_grp,
	input chkpt_pkg::checkpt_ndx_t avail,
	input logic stall,
	output logic alloc_req,
	output logic setcp,
	output chkpt_pkg::grp_ndx_t setcp_grp,
	output logic alloc_chkpt,
	output chkpt_pkg::checkpt_ndx_t cndx,
	output logic bko_free,
	output chkpt_pkg::checkpt_ndx_t bko_chkpt,
	output logic bko_busy,
	output logic squash
);
	import chkpt_pkg::*;

	chkpt_state_t state;
	grp_ndx_t last_grp;
	grp_ndx_t gndx;
	grp_ndx_t pend_grp;
	grp_ndx_t restore_grp;
	checkpt_ndx_t prev_cndx;
	checkpt_ndx_t scan_cndx;
	seq_t scan_age;
	logic restore_pend;
	logic take_restore;
	logic scan_more;

	// Dispatch stalls while a group waits, so only the youngest group can be pending.
	assign last_grp = tail - 1'b1;

	// A restore waits for idle and for any squash in flight to finish.
	assign take_restore = (restore || restore_pend) && state == idle && !squash;
	assign restore_grp = restore_pend ? pend_grp : miss_grp;

	// During backout setcp_grp holds the miss group.
	assign scan_cndx = hdr_cndx[gndx*CNDX_W +: CNDX_W];
	assign scan_age = hdr_sn[gndx*SEQ_W +: SEQ_W] - hdr_sn[setcp_grp*SEQ_W +: SEQ_W];
	assign scan_more = hdr_valid[gndx] && scan_age != '0 && !scan_age[SEQ_W-1];

	assign alloc_req = state == alloc2 && !stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			setcp <= 1'b0;
			alloc_chkpt <= 1'b0;
			cndx <= '0;
			bko_free <= 1'b0;
			bko_busy <= 1'b0;
			squash <= 1'b0;
			restore_pend <= 1'b0;
		end else begin
			setcp <= 1'b0;
			alloc_chkpt <= 1'b0;
			bko_free <= 1'b0;
			squash <= 1'b0;
			if (restore && !take_restore && !restore_pend)
				restore_pend <= 1'b1;
			case (state)
				idle: begin
					// The group stamped by setcp still shows cndxv low for this one cycle.
					if (take_restore) begin
						restore_pend <= 1'b0;
						cndx <= hdr_cndx[restore_grp*CNDX_W +: CNDX_W];
						bko_busy <= 1'b1;
						state <= backout;
					end else if (!squash && !setcp && hdr_valid[last_grp]
							&& !hdr_cndxv[last_grp]) begin
						state <= hdr_branch[last_grp] ? alloc1 : set;
					end
				end
				alloc1:
					state <= alloc2;
				alloc2: begin
					if (!stall) begin
						cndx <= avail;
						alloc_chkpt <= 1'b1;
						setcp <= 1'b1;
						state <= idle;
					end
				end
				set: begin
					setcp <= 1'b1;
					state <= idle;
				end
				backout: begin
					// Ends at the first slot that is not younger than the miss group.
					if (!scan_more) begin
						squash <= 1'b1;
						bko_busy <= 1'b0;
						state <= idle;
					end else if (hdr_cndxv[gndx] && scan_cndx != prev_cndx) begin
						bko_free <= 1'b1;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (restore && !restore_pend)
			pend_grp <= miss_grp;
		if (state == idle && take_restore) begin
			setcp_grp <= restore_grp;
			gndx <= restore_grp + 1'b1;
			prev_cndx <= hdr_cndx[restore_grp*CNDX_W +: CNDX_W];
		end else if (state == idle && !squash) begin
			setcp_grp <= last_grp;
		end
		if (state == backout && scan_more) begin
			gndx <= gndx + 1'b1;
			if (hdr_cndxv[gndx] && scan_cndx != prev_cndx) begin
				bko_chkpt <= scan_cndx;
				prev_cndx <= scan_cndx;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/chkpt_top.sv
`timescale 1ns/1ps
`default_nettype none

module chkpt_top (
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input logic disp_has_branch,
	output logic disp_ready,
	input logic commit_valid,
	output logic commit_ready,
	input logic restore,
	input chkpt_pkg::grp_ndx_t miss_grp,
	output logic setcp,
	output chkpt_pkg::grp_ndx_t setcp_grp,
	output logic alloc_chkpt,
	output chkpt_pkg::checkpt_ndx_t cndx,
	output logic freecp,
	output chkpt_pkg::grp_ndx_t freecp_grp
);
	import chkpt_pkg::*;

	logic [GROUP_COUNT-1:0] hdr_valid;
	logic [GROUP_COUNT-1:0] hdr_branch;
	logic [GROUP_COUNT-1:0] hdr_cndxv;
	logic [GROUP_COUNT*CNDX_W-1:0] hdr_cndx;
	logic [GROUP_COUNT*SEQ_W-1:0] hdr_sn;
	grp_ndx_t head;
	grp_ndx_t tail;
	logic commit_fire;
	logic alloc_req;
	logic bko_free;
	checkpt_ndx_t bko_chkpt;
	logic bko_busy;
	logic squash;
	logic cmt_free;
	checkpt_ndx_t cmt_chkpt;
	checkpt_ndx_t avail;
	logic stall;

	assign commit_fire = commit_valid && commit_ready;
	assign freecp = cmt_free || bko_free;

	// The manager holds the miss group on setcp_grp while it backs out.
	group_table group_table_inst (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_has_branch(disp_has_branch),
		.disp_ready(disp_ready),
		.commit_valid(commit_valid),
		.commit_ready(commit_ready),
		.setcp(setcp),
		.setcp_grp(setcp_grp),
		.cndx(cndx),
		.bko_busy(bko_busy),
		.squash(squash),
		.miss_grp(setcp_grp),
		.hdr_valid(hdr_valid),
		.hdr_branch(hdr_branch),
		.hdr_cndxv(hdr_cndxv),
		.hdr_cndx(hdr_cndx),
		.hdr_sn(hdr_sn),
		.head(head),
		.tail(tail)
	);

	chkpt_manager chkpt_manager_inst (
		.clk(clk),
		.rst(rst),
		.hdr_valid(hdr_valid),
		.hdr_branch(hdr_branch),
		.hdr_cndxv(hdr_cndxv),
		.hdr_cndx(hdr_cndx),
		.hdr_sn(hdr_sn),
		.tail(tail),
		.restore(restore),
		.miss_grp(miss_grp),
		.avail(avail),
		.stall(stall),
		.alloc_req(alloc_req),
		.setcp(setcp),
		.setcp_grp(setcp_grp),
		.alloc_chkpt(alloc_chkpt),
		.cndx(cndx),
		.bko_free(bko_free),
		.bko_chkpt(bko_chkpt),
		.bko_busy(bko_busy),
		.squash(squash)
	);

	chkpt_allocator chkpt_allocator_inst (
		.clk(clk),
		.rst(rst),
		.alloc_req(alloc_req),
		.cmt_free(cmt_free),
		.cmt_chkpt(cmt_chkpt),
		.bko_free(bko_free),
		.bko_chkpt(bko_chkpt),
		.avail(avail),
		.stall(stall)
	);

	chkpt_freer chkpt_freer_inst (
		.clk(clk),
		.rst(rst),
		.commit_fire(commit_fire),
		.head(head),
		.hdr_valid(hdr_valid),
		.hdr_cndx(hdr_cndx),
		.cndx(cndx),
		.cmt_free(cmt_free),
		.cmt_chkpt(cmt_chkpt),
		.freecp_grp(freecp_grp)
	);

endmodule

`default_nettype wire

// File: verification/chkpt_sva.sv
`timescale 1ns/1ps
`default_nettype none

module chkpt_sva (
	input logic clk,
	input logic rst,
	input chkpt_pkg::chkpt_state_t state,
	input logic stall,
	input logic setcp,
	input logic alloc_chkpt,
	input logic cmt_free,
	input chkpt_pkg::checkpt_ndx_t cmt_chkpt,
	input logic bko_free,
	input chkpt_pkg::checkpt_ndx_t bko_chkpt,
	input logic [chkpt_pkg::CHKPT_COUNT-1:0] free_map
);
	import chkpt_pkg::*;

	// A new checkpoint is always handed to a group in the same cycle.
	alloc_with_setcp: assert property (@(posedge clk) disable iff (rst)
		alloc_chkpt |-> setcp)
		else $error("alloc_chkpt pulsed without setcp");

	// An empty free list holds the manager in alloc2 with no setcp.
	no_set_while_stalled: assert property (@(posedge clk) disable iff (rst)
		(state == alloc2 && stall) |=> !setcp)
		else $error("setcp followed a stalled alloc2 cycle");

	// Both free ports must only return checkpoints that are in use.
	commit_frees_in_use: assert property (@(posedge clk) disable iff (rst)
		cmt_free |-> !free_map[cmt_chkpt])
		else $error("commit port freed a checkpoint that was already free");

	backout_frees_in_use: assert property (@(posedge clk) disable iff (rst)
		bko_free |-> !free_map[bko_chkpt])
		else $error("backout port freed a checkpoint that was already free");

endmodule

bind chkpt_top chkpt_sva chkpt_sva_inst (
	.clk(clk),
	.rst(rst),
	.state(chkpt_manager_inst.state),
	.stall(stall),
	.setcp(setcp),
	.alloc_chkpt(alloc_chkpt),
	.cmt_free(cmt_free),
	.cmt_chkpt(cmt_chkpt),
	.bko_free(bko_free),
	.bko_chkpt(bko_chkpt),
	.free_map(chkpt_allocator_inst.free_map)
);

`default_nettype wire

// File: verification/chkpt_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chkpt_tb;
	import chkpt_pkg::*;

	localparam logic [31:0] SEED = 32'hcb90f6c1;
	localparam int RAND_OPS = 95;
	localparam int DIRECTED_OPS = 30;
	// No single operation needs more than about a dozen cycles.
	localparam int OP_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = (RAND_OPS + DIRECTED_OPS) * OP_CYCLES;
	localparam int STALL_WAIT = 10;

	logic clk;
	logic rst;
	logic disp_valid;
	logic disp_has_branch;
	logic disp_ready;
	logic commit_valid;
	logic commit_ready;
	logic restore;
	grp_ndx_t miss_grp;
	logic setcp;
	grp_ndx_t setcp_grp;
	logic alloc_chkpt;
	checkpt_ndx_t cndx;
	logic freecp;
	grp_ndx_t freecp_grp;

	// Reference model of the ring, the free list and the current index.
	logic m_valid [GROUP_COUNT];
	int m_cp [GROUP_COUNT];
	logic m_free [CHKPT_COUNT];
	int m_head;
	int m_tail;
	int m_count;
	int m_cur;

	logic [31:0] lfsr;
	int cycle_count = 0;
	string test_name;

	chkpt_top chkpt_top_inst (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_has_branch(disp_has_branch),
		.disp_ready(disp_ready),
		.commit_valid(commit_valid),
		.commit_ready(commit_ready),
		.restore(restore),
		.miss_grp(miss_grp),
		.setcp(setcp),
		.setcp_grp(setcp_grp),
		.alloc_chkpt(alloc_chkpt),
		.cndx(cndx),
		.freecp(freecp),
		.freecp_grp(freecp_grp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	task check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("CHECK FAILED [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
			$display("** FAIL **");
			$fatal(1, "check failed");
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// The LFSR advances once for every bit taken.
	task take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic int lowest_free();
		for (int i = 0; i < CHKPT_COUNT; i++) begin
			if (m_free[i])
				return i;
		end
		return -1;
	endfunction

	task add_group(input int cp);
		m_valid[m_tail] = 1'b1;
		m_cp[m_tail] = cp;
		m_tail = (m_tail + 1) % GROUP_COUNT;
		m_count++;
	endtask

	task dispatch_group(input logic br);
		int cycles;
		int exp_cp;
		check_value("dispatch ready", 1, disp_ready);
		exp_cp = br ? lowest_free() : m_cur;
		disp_valid = 1'b1;
		disp_has_branch = br;
		@(negedge clk);
		disp_valid = 1'b0;
		cycles = 1;
		while (!setcp) begin
			@(negedge clk);
			cycles++;
		end
		check_value("setcp latency", br ? 4 : 3, cycles);
		check_value("setcp group", m_tail, setcp_grp);
		check_value("alloc pulse", br, alloc_chkpt);
		check_value("current index", exp_cp, cndx);
		if (br)
			m_free[exp_cp] = 1'b0;
		m_cur = exp_cp;
		add_group(exp_cp);
		@(negedge clk);
	endtask

	// The head's checkpoint is freed when its successor, or the current index, differs.
	task commit_group();
		int nxt;
		logic exp_free;
		check_value("commit ready", 1, commit_ready);
		nxt = (m_head + 1) % GROUP_COUNT;
		exp_free = m_valid[nxt] ? (m_cp[nxt] != m_cp[m_head]) : (m_cur != m_cp[m_head]);
		commit_valid = 1'b1;
		@(negedge clk);
		commit_valid = 1'b0;
		check_value("commit free", exp_free, freecp);
		if (exp_free) begin
			check_value("free group", m_head, freecp_grp);
			m_free[m_cp[m_head]] = 1'b1;
		end
		m_valid[m_head] = 1'b0;
		m_head = nxt;
		m_count--;
		@(negedge clk);
		check_value("single free pulse", 0, freecp);
	endtask

	task restore_group(input int g);
		int prev;
		int exp_frees;
		int frees;
		int j;
		prev = m_cp[g];
		exp_frees = 0;
		j = (g + 1) % GROUP_COUNT;
		while (j != m_tail) begin
			if (m_cp[j] != prev) begin
				m_free[m_cp[j]] = 1'b1;
				exp_frees++;
				prev = m_cp[j];
			end
			m_valid[j] = 1'b0;
			m_count--;
			j = (j + 1) % GROUP_COUNT;
		end
		miss_grp = grp_ndx_t'(g);
		restore = 1'b1;
		@(negedge clk);
		restore = 1'b0;
		check_value("restored index", m_cp[g], cndx);
		check_value("commit held in backout", 0, commit_ready);
		frees = 0;
		// Commit stays blocked until the scan and the squash are over.
		while (!commit_ready) begin
			if (freecp)
				frees++;
			@(negedge clk);
		end
		check_value("backout frees", exp_frees, frees);
		m_cur = m_cp[g];
		m_tail = (g + 1) % GROUP_COUNT;
	endtask

	// Seven branches take every free checkpoint, so the eighth must wait.
	task stall_test();
		int cp;
		repeat (7) dispatch_group(1'b1);
		check_value("dispatch ready", 1, disp_ready);
		disp_valid = 1'b1;
		disp_has_branch = 1'b1;
		@(negedge clk);
		disp_valid = 1'b0;
		repeat (STALL_WAIT) begin
			check_value("setcp while stalled", 0, setcp);
			@(negedge clk);
		end
		commit_group();
		while (!setcp)
			@(negedge clk);
		cp = lowest_free();
		check_value("stalled group", m_tail, setcp_grp);
		check_value("stalled alloc pulse", 1, alloc_chkpt);
		check_value("stalled index", cp, cndx);
		m_free[cp] = 1'b0;
		m_cur = cp;
		add_group(cp);
		@(negedge clk);
	endtask

	task random_ops();
		int op;
		int br;
		int off;
		for (int n = 0; n < RAND_OPS; n++) begin
			take_bits(2, op);
			if (op == 3 && m_count > 0) begin
				take_bits(3, off);
				restore_group((m_head + off % m_count) % GROUP_COUNT);
			end else if ((op == 2 || m_count == GROUP_COUNT) && m_count >= 2) begin
				commit_group();
			end else begin
				take_bits(1, br);
				if (lowest_free() < 0)
					br = 0;
				dispatch_group(br[0]);
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_has_branch = 1'b0;
		commit_valid = 1'b0;
		restore = 1'b0;
		miss_grp = '0;
		lfsr = SEED;
		for (int i = 0; i < GROUP_COUNT; i++)
			m_valid[i] = 1'b0;
		for (int i = 0; i < CHKPT_COUNT; i++)
			m_free[i] = (i != 0);
		m_head = 0;
		m_tail = 0;
		m_count = 0;
		m_cur = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		test_name = "reset";
		check_value("setcp", 0, setcp);
		check_value("alloc_chkpt", 0, alloc_chkpt);
		check_value("freecp", 0, freecp);
		check_value("cndx", 0, cndx);
		check_value("disp_ready", 1, disp_ready);
		check_value("commit_ready", 0, commit_ready);

		test_name = "stall";
		stall_test();

		test_name = "non-branch";
		dispatch_group(1'b0);
		check_value("full ring", 0, disp_ready);

		test_name = "commit";
		repeat (7) commit_group();

		test_name = "reuse";
		dispatch_group(1'b1);
		dispatch_group(1'b1);
		dispatch_group(1'b0);

		test_name = "restore";
		restore_group((m_head + 1) % GROUP_COUNT);
		dispatch_group(1'b1);

		test_name = "random";
		random_ops();

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
logic/chkpt_pkg.sv
logic/group_table.sv
logic/chkpt_allocator.sv
logic/chkpt_freer.sv
logic/chkpt_manager.sv
logic/chkpt_top.sv
verification/chkpt_sva.sv
verification/chkpt_tb.sv
